// File: hw/rv_pkg.sv
// shared widths, opcodes and stage payload types for the rv32i pipeline core
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	// operand source for the execute stage
	typedef enum logic [1:0] {
		fwd_rf,
		fwd_mem,
		fwd_wb
	} forward_sel_t;

	// ------------------------------
	// base opcodes
	// ------------------------------
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src;
		logic    branch;
		logic    branch_ne;
		alu_op_t alu_op;
	} ctrl_t;

	// ------------------------------
	// stage payloads
	// ------------------------------
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] immediate;
		reg_addr_t       rs1;
		reg_addr_t       rs2;
		reg_addr_t       rd;
	} id_ex_t;

	typedef struct packed {
		logic            reg_write;
		logic            mem_read;
		logic            mem_write;
		logic            mem_to_reg;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] store_data;
		reg_addr_t       rd;
	} ex_mem_t;

	typedef struct packed {
		logic            reg_write;
		logic            mem_to_reg;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] load_data;
		reg_addr_t       rd;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: hw/rv_hazard_if.sv
// stage register tags from the core to the hazard unit and its decisions back
`timescale 1ns/10ps
`default_nettype none

interface rv_hazard_if (input wire logic clk);

	rv_pkg::reg_addr_t    id_rs1, id_rs2;
	rv_pkg::reg_addr_t    ex_rs1, ex_rs2, ex_rd;
	logic                 ex_mem_read;
	rv_pkg::reg_addr_t    mem_rd, wb_rd;
	logic                 mem_reg_write, wb_reg_write;
	rv_pkg::forward_sel_t fwd_a, fwd_b;
	logic                 load_use;

	modport core (
		output id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
			mem_rd, mem_reg_write, wb_rd, wb_reg_write,
		input  fwd_a, fwd_b, load_use
	);

	modport hazard (
		input  clk, id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
			mem_rd, mem_reg_write, wb_rd, wb_reg_write,
		output fwd_a, fwd_b, load_use
	);

endinterface

`default_nettype wire

// File: hw/rv_stage_reg.sv
// pipeline boundary register with hold and bubble, one instance per stage boundary
`timescale 1ns/10ps
`default_nettype none

module rv_stage_reg #(
	parameter type payload_t = logic
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic hold,
	input  wire logic bubble,
	input  payload_t  d,
	output payload_t  q
);

	// hold beats bubble, bubble beats load
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= '0;
		end else if (hold) begin
			q <= q;
		end else if (bubble) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

	// a stalled stage must not lose its instruction to a flush
	hold_over_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		(hold && bubble) |=> $stable(q));

endmodule

`default_nettype wire

// File: hw/rv_decoder.sv
// instruction decode into control fields, alu operation and sign-extended immediate
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
	input  wire logic [31:0] instr,
	output rv_pkg::ctrl_t    ctrl,
	output logic [31:0]      immediate
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       sub_bit;
	rv_pkg::alu_op_t fn_op;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	// funct7 only matters for register-register ops, addi may have bit 30 set
	assign sub_bit = (opcode == rv_pkg::opc_op) && instr[30];

	always_comb begin
		case (funct3)
			3'b000: fn_op = sub_bit ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b010: fn_op = rv_pkg::alu_slt;
			3'b110: fn_op = rv_pkg::alu_or;
			3'b111: fn_op = rv_pkg::alu_and;
			default: fn_op = rv_pkg::alu_add;
		endcase
	end

	// ------------------------------
	// control fields
	// ------------------------------
	always_comb begin
		ctrl = '0;
		case (opcode)
			rv_pkg::opc_op: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = fn_op;
			end
			rv_pkg::opc_op_imm: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = fn_op;
			end
			rv_pkg::opc_load: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
			end
			rv_pkg::opc_store: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			rv_pkg::opc_branch: begin
				// compare by subtraction, funct3[0] picks bne
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = funct3[0];
				ctrl.alu_op    = rv_pkg::alu_sub;
			end
			default: ctrl = '0;
		endcase
	end

	// immediate formats, i-type unless store or branch
	always_comb begin
		case (opcode)
			rv_pkg::opc_store:
				immediate = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rv_pkg::opc_branch:
				immediate = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			default:
				immediate = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
// integer register file, two read ports and one write port with same-cycle bypass
`timescale 1ns/10ps
`default_nettype none

module rv_regfile #(
	parameter int width = 32
) (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  rv_pkg::reg_addr_t     rs1,
	input  rv_pkg::reg_addr_t     rs2,
	output logic [width-1:0]      rs1_data,
	output logic [width-1:0]      rs2_data,
	input  rv_pkg::reg_addr_t     rd,
	input  wire logic [width-1:0] rd_data,
	input  wire logic             we
);

	// x0 has no storage
	logic [width-1:0] regs [31:1];
	logic             wr_hit;

	assign wr_hit = we && (rd != '0);

	always_ff @(posedge clk) begin
		if (rst_n && wr_hit) begin
			regs[rd] <= rd_data;
		end
	end

	// writeback result visible to decode in the same cycle
	assign rs1_data = (rs1 == '0) ? '0 : (wr_hit && rd == rs1) ? rd_data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : (wr_hit && rd == rs2) ? rd_data : regs[rs2];

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
// execute-stage alu for add, sub, and, or and signed slt, with a zero flag for branches
`timescale 1ns/10ps
`default_nettype none

module rv_alu #(
	parameter int width = 32
) (
	input  rv_pkg::alu_op_t        op,
	input  wire logic [width-1:0]  a,
	input  wire logic [width-1:0]  b,
	output logic [width-1:0]       result,
	output logic                   zero
);

	logic less;

	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			rv_pkg::alu_add: result = a + b;
			rv_pkg::alu_sub: result = a - b;
			rv_pkg::alu_and: result = a & b;
			rv_pkg::alu_or:  result = a | b;
			rv_pkg::alu_slt: result = {{(width-1){1'b0}}, less};
			default:         result = a + b;
		endcase
	end

	// beq/bne look at this after a sub
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/rv_hazard.sv
// operand forwarding selection and load-use bubble detection
`timescale 1ns/10ps
`default_nettype none

module rv_hazard (
	rv_hazard_if.hazard hz
);

	// youngest writer wins, x0 never forwards
	function automatic rv_pkg::forward_sel_t pick_src(input rv_pkg::reg_addr_t rs);
		rv_pkg::forward_sel_t sel;
		if (hz.mem_reg_write && hz.mem_rd != '0 && hz.mem_rd == rs) begin
			sel = rv_pkg::fwd_mem;
		end else if (hz.wb_reg_write && hz.wb_rd != '0 && hz.wb_rd == rs) begin
			sel = rv_pkg::fwd_wb;
		end else begin
			sel = rv_pkg::fwd_rf;
		end
		return sel;
	endfunction

	assign hz.fwd_a = pick_src(hz.ex_rs1);
	assign hz.fwd_b = pick_src(hz.ex_rs2);

	// ------------------------------
	// load-use
	// ------------------------------
	// rs2 of i-type instructions may match by accident, costs one spare bubble
	assign hz.load_use = hz.ex_mem_read && (hz.ex_rd != '0) &&
		((hz.ex_rd == hz.id_rs1) || (hz.ex_rd == hz.id_rs2));

	// a load into x0 has nothing to wait for
	no_x0_stall: assert property (@(posedge hz.clk)
		hz.load_use |-> (hz.ex_rd != '0));

endmodule

`default_nettype wire

// File: hw/rv_core.sv
// five-stage rv32i core top, wired straight to instruction rom and data memory ports
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
	parameter int width = rv_pkg::xlen
) (
	input  wire logic             clk,
	input  wire logic             rst_n,
	output logic [width-3:0]      imem_addr,
	input  wire logic [31:0]      imem_data,
	output logic                  dmem_valid,
	output logic                  dmem_write,
	output logic [width-3:0]      dmem_addr,
	output logic [width-1:0]      dmem_wdata,
	input  wire logic [width-1:0] dmem_rdata,
	input  wire logic             dmem_ready
);

	logic [width-1:0] pc;
	logic             stall;
	logic             take_branch;
	logic [width-1:0] branch_target;

	rv_pkg::if_id_t  if_id_d, if_id_q;
	rv_pkg::id_ex_t  id_ex_d, id_ex_q;
	rv_pkg::ex_mem_t ex_mem_d, ex_mem_q;
	rv_pkg::mem_wb_t mem_wb_d, mem_wb_q;

	rv_pkg::ctrl_t    dec_ctrl;
	logic [31:0]      dec_imm;
	logic [width-1:0] rf_rs1_data, rf_rs2_data;
	logic [width-1:0] op_a, rs2_fwd, op_b;
	logic [width-1:0] alu_result;
	logic             alu_zero;
	logic [width-1:0] wb_data;

	rv_hazard_if hz (.clk(clk));

	// data memory holding back freezes the whole pipe
	assign stall = dmem_valid && !dmem_ready;

	// ------------------------------
	// fetch
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (stall) begin
			pc <= pc;
		end else if (take_branch) begin
			pc <= branch_target;
		end else if (!hz.load_use) begin
			pc <= pc + width'(4);
		end
	end

	assign imem_addr = pc[width-1:2];
	assign if_id_d = '{pc: pc, instr: imem_data};

	rv_stage_reg #(.payload_t(rv_pkg::if_id_t)) u_if_id (
		.clk(clk), .rst_n(rst_n), .hold(stall || hz.load_use),
		.bubble(take_branch), .d(if_id_d), .q(if_id_q)
	);

	// ------------------------------
	// decode
	// ------------------------------
	rv_decoder u_decoder (.instr(if_id_q.instr), .ctrl(dec_ctrl), .immediate(dec_imm));

	rv_regfile #(.width(width)) u_regfile (
		.clk(clk), .rst_n(rst_n),
		.rs1(if_id_q.instr[19:15]), .rs2(if_id_q.instr[24:20]),
		.rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
		.rd(mem_wb_q.rd), .rd_data(wb_data), .we(mem_wb_q.reg_write)
	);

	always_comb begin
		id_ex_d.ctrl      = dec_ctrl;
		id_ex_d.pc        = if_id_q.pc;
		id_ex_d.rs1_data  = rf_rs1_data;
		id_ex_d.rs2_data  = rf_rs2_data;
		id_ex_d.immediate = dec_imm;
		id_ex_d.rs1       = if_id_q.instr[19:15];
		id_ex_d.rs2       = if_id_q.instr[24:20];
		id_ex_d.rd        = if_id_q.instr[11:7];
	end

	// load-use inserts a bubble, a taken branch squashes the decoded instruction
	rv_stage_reg #(.payload_t(rv_pkg::id_ex_t)) u_id_ex (
		.clk(clk), .rst_n(rst_n), .hold(stall),
		.bubble(hz.load_use || take_branch), .d(id_ex_d), .q(id_ex_q)
	);

	// ------------------------------
	// execute
	// ------------------------------
	assign hz.id_rs1        = if_id_q.instr[19:15];
	assign hz.id_rs2        = if_id_q.instr[24:20];
	assign hz.ex_rs1        = id_ex_q.rs1;
	assign hz.ex_rs2        = id_ex_q.rs2;
	assign hz.ex_rd         = id_ex_q.rd;
	assign hz.ex_mem_read   = id_ex_q.ctrl.mem_read;
	assign hz.mem_rd        = ex_mem_q.rd;
	assign hz.mem_reg_write = ex_mem_q.reg_write;
	assign hz.wb_rd         = mem_wb_q.rd;
	assign hz.wb_reg_write  = mem_wb_q.reg_write;

	rv_hazard u_hazard (.hz(hz));

	always_comb begin
		case (hz.fwd_a)
			rv_pkg::fwd_mem: op_a = ex_mem_q.alu_result;
			rv_pkg::fwd_wb:  op_a = wb_data;
			default:         op_a = id_ex_q.rs1_data;
		endcase
		case (hz.fwd_b)
			rv_pkg::fwd_mem: rs2_fwd = ex_mem_q.alu_result;
			rv_pkg::fwd_wb:  rs2_fwd = wb_data;
			default:         rs2_fwd = id_ex_q.rs2_data;
		endcase
	end

	assign op_b = id_ex_q.ctrl.alu_src ? id_ex_q.immediate : rs2_fwd;

	rv_alu #(.width(width)) u_alu (
		.op(id_ex_q.ctrl.alu_op), .a(op_a), .b(op_b), .result(alu_result), .zero(alu_zero)
	);

	// beq on equal, bne on not equal
	assign take_branch = id_ex_q.ctrl.branch && (id_ex_q.ctrl.branch_ne ^ alu_zero);
	assign branch_target = id_ex_q.pc + id_ex_q.immediate;

	assign ex_mem_d = '{reg_write: id_ex_q.ctrl.reg_write, mem_read: id_ex_q.ctrl.mem_read,
		mem_write: id_ex_q.ctrl.mem_write, mem_to_reg: id_ex_q.ctrl.mem_to_reg,
		alu_result: alu_result, store_data: rs2_fwd, rd: id_ex_q.rd};

	rv_stage_reg #(.payload_t(rv_pkg::ex_mem_t)) u_ex_mem (
		.clk(clk), .rst_n(rst_n), .hold(stall), .bubble(1'b0), .d(ex_mem_d), .q(ex_mem_q)
	);

	// ------------------------------
	// memory and writeback
	// ------------------------------
	assign dmem_valid = ex_mem_q.mem_read || ex_mem_q.mem_write;
	assign dmem_write = ex_mem_q.mem_write;
	assign dmem_addr  = ex_mem_q.alu_result[width-1:2];
	assign dmem_wdata = ex_mem_q.store_data;

	assign mem_wb_d = '{reg_write: ex_mem_q.reg_write, mem_to_reg: ex_mem_q.mem_to_reg,
		alu_result: ex_mem_q.alu_result, load_data: dmem_rdata, rd: ex_mem_q.rd};

	rv_stage_reg #(.payload_t(rv_pkg::mem_wb_t)) u_mem_wb (
		.clk(clk), .rst_n(rst_n), .hold(stall), .bubble(1'b0), .d(mem_wb_d), .q(mem_wb_q)
	);

	assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

	// request must stay put until the memory takes it
	dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_valid && !dmem_ready) |=>
			($stable(dmem_addr) && $stable(dmem_wdata) && $stable(dmem_write)));

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// clock and reset source for the core testbench, 10 ns period and reset held for 16 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int reset_cycles = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// release just after a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/tb_mem.sv
// program rom, data memory with random ready and the store table that the testbench top wires to the core
`timescale 1ns/10ps
`default_nettype none

module tb_mem (
	input  wire logic        clk,
	input  wire logic [29:0] imem_addr,
	output logic [31:0]      imem_data,
	input  wire logic        dmem_valid,
	input  wire logic        dmem_write,
	input  wire logic [29:0] dmem_addr,
	input  wire logic [31:0] dmem_wdata,
	output logic [31:0]      dmem_rdata,
	output logic             dmem_ready,
	output logic [29:0]      exp_addr,
	output logic [31:0]      exp_data,
	output int               store_count,
	output logic             all_stored,
	output logic             marker_seen
);

	localparam int          prog_len    = 24;
	localparam int          table_len   = 9;
	localparam logic [29:0] marker_addr = 30'd60;
	localparam logic [31:0] nop         = 32'h00000013;

	// ------------------------------
	// program
	// ------------------------------
	localparam logic [31:0] program_words [prog_len] = '{
		32'h00500093, // addi x1, x0, 5
		32'h00700113, // addi x2, x0, 7
		32'h002081b3, // add  x3, x1, x2
		32'h00302223, // sw   x3, 4(x0)
		32'h40118233, // sub  x4, x3, x1
		32'h00402423, // sw   x4, 8(x0)
		32'h0020f2b3, // and  x5, x1, x2
		32'h00502623, // sw   x5, 12(x0)
		32'h0020e333, // or   x6, x1, x2
		32'h00602823, // sw   x6, 16(x0)
		32'h0020a3b3, // slt  x7, x1, x2
		32'h00702a23, // sw   x7, 20(x0)
		32'h05002403, // lw   x8, 80(x0)
		32'h00140493, // addi x9, x8, 1
		32'h00902c23, // sw   x9, 24(x0)
		32'h00108663, // beq  x1, x1, +12
		32'h06300293, // addi x5, x0, 99
		32'h06200293, // addi x5, x0, 98
		32'h00502e23, // sw   x5, 28(x0)
		32'h00109463, // bne  x1, x1, +8
		32'h00328513, // addi x10, x5, 3
		32'h02a02023, // sw   x10, 32(x0)
		32'h0e102823, // sw   x1, 240(x0) as the marker
		32'h00000063  // beq  x0, x0, 0
	};

	// expected stores in program order
	localparam logic [29:0] store_addrs [table_len] = '{
		30'd1, 30'd2, 30'd3, 30'd4, 30'd5, 30'd6, 30'd7, 30'd8, marker_addr
	};
	localparam logic [31:0] store_values [table_len] = '{
		32'd12, 32'd7, 32'd5, 32'd7, 32'd1, 32'd101, 32'd5, 32'd8, 32'd5
	};

	logic [31:0] data_mem [64];
	logic [31:0] rng_state;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign imem_data = (imem_addr < 30'(prog_len)) ? program_words[imem_addr[4:0]] : nop;
	assign dmem_rdata = data_mem[dmem_addr[5:0]];

	assign all_stored = (store_count == table_len);
	assign exp_addr = (store_count < table_len) ? store_addrs[store_count[3:0]] : '1;
	assign exp_data = (store_count < table_len) ? store_values[store_count[3:0]] : '1;

	// ------------------------------
	// data memory
	// ------------------------------
	initial begin
		// every word carries its own index so a wrong address reads a visible value
		for (int i = 0; i < 64; i++) begin
			data_mem[i] = 32'h5a5a0000 | 32'(i);
		end
		data_mem[20] = 32'd100;
		store_count = 0;
		marker_seen = 1'b0;
		forever begin
			@(posedge clk);
			if (dmem_valid && dmem_ready && dmem_write) begin
				data_mem[dmem_addr[5:0]] <= dmem_wdata;
				store_count <= store_count + 1;
				if (dmem_addr == marker_addr) begin
					marker_seen <= 1'b1;
				end
			end
		end
	end

	// ready low on about one cycle in three
	initial begin
		rng_state = 32'h677312f6;
		dmem_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			rng_state = xorshift32(rng_state);
			dmem_ready = (rng_state % 32'd3) != 32'd0;
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
// simulation top that runs the fixed program on the core and checks every data port transfer
`timescale 1ns/10ps
`default_nettype none

module tb_top;

	localparam int reset_timeout = 100;
	localparam int run_timeout   = 2000;
	localparam int drain_cycles  = 20;

	logic        clk;
	logic        rst_n;
	logic [29:0] imem_addr;
	logic [31:0] imem_data;
	logic        dmem_valid;
	logic        dmem_write;
	logic [29:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [31:0] dmem_rdata;
	logic        dmem_ready;
	logic [29:0] exp_addr;
	logic [31:0] exp_data;
	int          store_count;
	logic        all_stored;
	logic        marker_seen;

	int value_errors = 0;
	int other_errors = 0;
	int cycle = 0;
	int waited;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	tb_mem u_mem (
		.clk(clk), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_valid(dmem_valid), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready),
		.exp_addr(exp_addr), .exp_data(exp_data), .store_count(store_count),
		.all_stored(all_stored), .marker_seen(marker_seen)
	);

	rv_core #(.width(32)) u_dut (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_valid(dmem_valid), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready)
	);

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
		value_errors++;
	endtask

	task automatic note_failure(input string what);
		$display("%0t failure: %s", $time, what);
		other_errors++;
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// ------------------------------
	// reset and the cycle after it
	// ------------------------------
	reset_valid: assert property (@(posedge clk) (cycle > 0 && $past(!rst_n)) |-> !dmem_valid)
		else report_mismatch("dmem_valid", 32'($sampled(dmem_valid)), 32'd0);
	reset_pc: assert property (@(posedge clk) (cycle > 0 && $past(!rst_n)) |-> imem_addr == '0)
		else report_mismatch("imem_addr", 32'($sampled(imem_addr)), 32'd0);

	// each completed store is matched with the next table entry so gaps and duplicates show up
	store_addr: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_valid && dmem_ready && dmem_write) |-> dmem_addr == exp_addr)
		else report_mismatch("dmem_addr", 32'($sampled(dmem_addr)), 32'($sampled(exp_addr)));
	store_data: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_valid && dmem_ready && dmem_write) |-> dmem_wdata == exp_data)
		else report_mismatch("dmem_wdata", $sampled(dmem_wdata), $sampled(exp_data));

	// ------------------------------
	// back-pressure
	// ------------------------------
	hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_valid && !dmem_ready) |=> dmem_valid)
		else report_mismatch("dmem_valid", 32'($sampled(dmem_valid)), 32'd1);
	hold_addr: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_valid && !dmem_ready) |=> $stable(dmem_addr))
		else report_mismatch("dmem_addr", 32'($sampled(dmem_addr)), 32'($past(dmem_addr)));
	hold_wdata: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_valid && !dmem_ready) |=> $stable(dmem_wdata))
		else report_mismatch("dmem_wdata", $sampled(dmem_wdata), $past(dmem_wdata));
	hold_write: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_valid && !dmem_ready) |=> $stable(dmem_write))
		else report_mismatch("dmem_write", 32'($sampled(dmem_write)), 32'($past(dmem_write)));

	initial begin
		waited = 0;
		while (!rst_n && waited < reset_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (!rst_n) begin
			note_failure("reset was never released");
		end else begin
			waited = 0;
			while (!marker_seen && waited < run_timeout) begin
				@(negedge clk);
				waited++;
			end
			if (!marker_seen) begin
				note_failure("marker store did not arrive before the timeout");
			end
			// idle cycles to catch any store after the marker
			repeat (drain_cycles) @(negedge clk);
			completion: assert (all_stored)
				else note_failure($sformatf("%0d stores seen, which is not the table length",
					store_count));
		end
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hw/rv_pkg.sv
hw/rv_hazard_if.sv
hw/rv_stage_reg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_hazard.sv
hw/rv_core.sv
bench/tb_clock.sv
bench/tb_mem.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_top -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
